//--- design/arcade_cfg.svh
// Memory map and count macros for the ROM front end
`ifndef ARCADE_CFG_SVH
`define ARCADE_CFG_SVH

// Byte address of the first PROM, each PROM takes 256 bytes
`define PROM_START  25'h0A_0000

`define PROM_COUNT  12

// Slot 0 char, slot 1 scroll, slot 2 main
`define SLOT_COUNT  3

// SDRAM word offsets
`define MAIN_OFFSET 22'h00_0000
`define CHAR_OFFSET 22'h02_0000
`define SCR_OFFSET  22'h03_0000

`endif

//--- design/arcade_pkg.sv
// Packed structs for the download, SDRAM, ROM slot and clock enable buses
`default_nettype none

package arcade_pkg;

    // One byte from the download stream
    typedef struct packed {
        logic [24:0] addr;
        logic [7:0]  dout;
        logic        wr;
    } ioctl_t;

    // SDRAM programming write
    typedef struct packed {
        logic [21:0] addr;   // Word address
        logic [7:0]  data;
        logic [1:0]  mask;   // Active low byte lanes
        logic        we;
    } prog_t;

    // Fetch request towards SDRAM
    typedef struct packed {
        logic        req;
        logic [21:0] addr;
    } sdram_req_t;

    // SDRAM answer, ack while downloading means write accepted
    typedef struct packed {
        logic        ack;
        logic        rdy;
        logic [15:0] data;
    } sdram_rsp_t;

    typedef struct packed {
        logic        cs;
        logic [16:0] addr;   // Word address inside the slot
    } rom_req_t;

    typedef struct packed {
        logic        ok;
        logic [15:0] data;
    } rom_rsp_t;

    // Pixel clock enables from 48 MHz
    typedef struct packed {
        logic cen12;
        logic cen6;
        logic cen3;
    } cen_t;

endpackage

`default_nettype wire

//--- design/cen_gen.sv
// Clock enable generator for 12, 6 and 3 MHz pulses from a 48 MHz clock
`default_nettype none

module cen_gen (
    input  wire              clk,
    input  wire              rst_n,
    output arcade_pkg::cen_t cen
);

    logic [3:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= 4'd0;
            cen <= '0;
        end else begin
            cnt       <= cnt + 4'd1;
            cen.cen12 <= &cnt[1:0];  // Divide by 4
            cen.cen6  <= &cnt[2:0];  // Divide by 8
            cen.cen3  <= &cnt;       // Divide by 16
        end
    end

endmodule

`default_nettype wire

//--- design/rom_dwnld.sv
// Download unit turning ioctl bytes into SDRAM writes and PROM write strobes
`default_nettype none
`include "arcade_cfg.svh"

module rom_dwnld (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     downloading,
    input  arcade_pkg::ioctl_t      ioctl,
    input  wire                     sdram_ack,
    output arcade_pkg::prog_t       prog,
    output logic [`PROM_COUNT-1:0]  prom_we
);

    logic [24:0] prom_off;
    logic [3:0]  prom_sel;
    logic        is_prom;
    logic        accept;

    logic [21:0] addr_q;
    logic [7:0]  data_q;
    logic [1:0]  mask_q;
    logic        we_q;

    assign is_prom  = ioctl.addr >= `PROM_START;
    assign prom_off = ioctl.addr - `PROM_START;
    assign prom_sel = prom_off[11:8];  // One PROM per 256 bytes

    // Bytes arriving while a write is pending are lost
    assign accept = downloading && ioctl.wr && !we_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q    <= 1'b0;
            prom_we <= '0;
        end else begin
            prom_we <= '0;
            if (we_q && downloading && sdram_ack)
                we_q <= 1'b0;
            if (accept && !is_prom)
                we_q <= 1'b1;
            if (accept && is_prom && prom_sel < `PROM_COUNT)
                prom_we[prom_sel] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= ioctl.dout;
            if (is_prom) begin
                addr_q <= {14'd0, prom_off[7:0]};  // PROM local address
                mask_q <= 2'b11;
            end else begin
                addr_q <= ioctl.addr[22:1];
                mask_q <= ioctl.addr[0] ? 2'b01 : 2'b10;  // Odd byte uses upper lane
            end
        end
    end

    assign prog = '{addr: addr_q, data: data_q, mask: mask_q, we: we_q};

endmodule

`default_nettype wire

//--- design/rom_slots.sv
// Three-slot ROM fetcher sharing one SDRAM port, fixed priority, one word cache per slot
`default_nettype none
`include "arcade_cfg.svh"

module rom_slots (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    downloading,
    input  arcade_pkg::rom_req_t   rom_req [`SLOT_COUNT],
    output arcade_pkg::rom_rsp_t   rom_rsp [`SLOT_COUNT],
    output arcade_pkg::sdram_req_t sdram_req,
    input  arcade_pkg::sdram_rsp_t sdram_rsp
);

    localparam int slot_w = $clog2(`SLOT_COUNT);
    localparam logic [21:0] slot_offset [`SLOT_COUNT] = '{
        `CHAR_OFFSET, `SCR_OFFSET, `MAIN_OFFSET
    };

    typedef enum logic [1:0] {
        st_idle,
        st_ack,  // Request held until ack
        st_rdy   // Waiting for the data word
    } state_t;

    state_t              state;
    logic [slot_w-1:0]   cur_slot;
    logic [16:0]         fetch_addr;
    logic [21:0]         addr_q;
    logic                req_q;

    logic [16:0]         cache_addr [`SLOT_COUNT];
    logic [15:0]         cache_data [`SLOT_COUNT];
    logic [`SLOT_COUNT-1:0] cache_valid;

    logic [`SLOT_COUNT-1:0] hit;
    logic [`SLOT_COUNT-1:0] miss;
    logic                pick_valid;
    logic [slot_w-1:0]   pick_slot;

    always_comb begin
        for (int i = 0; i < `SLOT_COUNT; i++) begin
            hit[i]          = cache_valid[i] && cache_addr[i] == rom_req[i].addr;
            miss[i]         = rom_req[i].cs && !hit[i];
            rom_rsp[i].ok   = rom_req[i].cs && hit[i];
            rom_rsp[i].data = cache_data[i];
        end
    end

    // Lowest slot number wins
    always_comb begin
        pick_valid = 1'b0;
        pick_slot  = '0;
        for (int i = `SLOT_COUNT - 1; i >= 0; i--) begin
            if (miss[i]) begin
                pick_valid = 1'b1;
                pick_slot  = slot_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_idle;
            req_q       <= 1'b0;
            cur_slot    <= '0;
            cache_valid <= '0;
        end else if (downloading) begin
            // SDRAM belongs to the download, cached words go stale
            state       <= st_idle;
            req_q       <= 1'b0;
            cache_valid <= '0;
        end else begin
            case (state)
                st_idle: if (pick_valid) begin
                    state      <= st_ack;
                    req_q      <= 1'b1;
                    cur_slot   <= pick_slot;
                    fetch_addr <= rom_req[pick_slot].addr;
                    addr_q     <= slot_offset[pick_slot] + {5'd0, rom_req[pick_slot].addr};
                end
                st_ack: if (sdram_rsp.ack) begin
                    state <= st_rdy;
                    req_q <= 1'b0;
                end
                st_rdy: if (sdram_rsp.rdy) begin
                    state                 <= st_idle;
                    cache_valid[cur_slot] <= 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Cache contents, qualified by cache_valid
    always_ff @(posedge clk) begin
        if (state == st_rdy && sdram_rsp.rdy) begin
            cache_addr[cur_slot] <= fetch_addr;
            cache_data[cur_slot] <= sdram_rsp.data;
        end
    end

    assign sdram_req = '{req: req_q, addr: addr_q};

endmodule

`default_nettype wire

//--- design/arcade_rom_top.sv
// Top level of the ROM front end with clock enables, download unit and slot fetcher
`default_nettype none
`include "arcade_cfg.svh"

module arcade_rom_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     downloading,
    input  arcade_pkg::ioctl_t      ioctl,
    input  arcade_pkg::rom_req_t    rom_req [`SLOT_COUNT],
    input  arcade_pkg::sdram_rsp_t  sdram_rsp,
    output arcade_pkg::cen_t        cen,
    output arcade_pkg::prog_t       prog,
    output wire [`PROM_COUNT-1:0]   prom_we,
    output arcade_pkg::rom_rsp_t    rom_rsp [`SLOT_COUNT],
    output arcade_pkg::sdram_req_t  sdram_req
);

    cen_gen i_cen (
        .clk    ( clk   ),
        .rst_n  ( rst_n ),
        .cen    ( cen   )
    );

    // Ack means write accepted while downloading
    rom_dwnld i_dwnld (
        .clk         ( clk           ),
        .rst_n       ( rst_n         ),
        .downloading ( downloading   ),
        .ioctl       ( ioctl         ),
        .sdram_ack   ( sdram_rsp.ack ),
        .prog        ( prog          ),
        .prom_we     ( prom_we       )
    );

    rom_slots i_slots (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .rom_req     ( rom_req     ),
        .rom_rsp     ( rom_rsp     ),
        .sdram_req   ( sdram_req   ),
        .sdram_rsp   ( sdram_rsp   )
    );

endmodule

`default_nettype wire

//--- sim/arcade_rom_properties.sv
// Concurrent assertions on the top-level handshakes, bound to arcade_rom_top
`default_nettype none
`include "arcade_cfg.svh"

module arcade_rom_properties (
    input wire                     clk,
    input wire                     rst_n,
    input wire                     downloading,
    input wire [`PROM_COUNT-1:0]   prom_we,
    input arcade_pkg::prog_t       prog,
    input arcade_pkg::sdram_req_t  sdram_req,
    input arcade_pkg::sdram_rsp_t  sdram_rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    prom_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(prom_we))
        else $error("prom_we has more than one bit set");

    // Fetch request held until ack
    req_hold: assert property (@(posedge clk) disable iff (!rst_n || downloading)
        sdram_req.req && !sdram_rsp.ack |=> sdram_req.req && $stable(sdram_req.addr))
        else $error("sdram_req dropped or changed before ack");

    prog_hold: assert property (@(posedge clk) disable iff (!rst_n)
        prog.we && !sdram_rsp.ack |=> prog.we && $stable(prog))
        else $error("prog write dropped or changed before ack");

    no_req_dl: assert property (@(posedge clk) disable iff (!rst_n)
        downloading && $past(downloading) |-> !sdram_req.req)
        else $error("sdram_req raised while downloading");

endmodule

bind arcade_rom_top arcade_rom_properties i_props (
    .clk(clk), .rst_n(rst_n), .downloading(downloading), .prom_we(prom_we),
    .prog(prog), .sdram_req(sdram_req), .sdram_rsp(sdram_rsp)
);

`default_nettype wire

//--- sim/arcade_rom_tb.sv
// Directed testbench for arcade_rom_top with SDRAM model, test tasks, compare tasks and watchdog
`default_nettype none
`include "arcade_cfg.svh"

module arcade_rom_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int watch_cycles = 64 + 150 + 100 + 250 + 150 + 250 + 300;
    localparam logic [21:0] slot_off [`SLOT_COUNT] = '{
        `CHAR_OFFSET, `SCR_OFFSET, `MAIN_OFFSET
    };

    logic clk = 1'b0;
    logic rst_n;
    logic downloading;
    arcade_pkg::ioctl_t     ioctl;
    arcade_pkg::rom_req_t   rom_req [`SLOT_COUNT];
    arcade_pkg::sdram_rsp_t sdram_rsp = '0;
    arcade_pkg::cen_t       cen;
    arcade_pkg::prog_t      prog;
    logic [`PROM_COUNT-1:0] prom_we;
    arcade_pkg::rom_rsp_t   rom_rsp [`SLOT_COUNT];
    arcade_pkg::sdram_req_t sdram_req;

    int errors = 0;
    int checks = 0;
    int tests  = 0;
    int mphase;
    int mcount;
    logic        m_fetch;
    logic [21:0] m_addr;
    arcade_pkg::sdram_req_t fetch_log [$];
    logic [16:0] cur_addr [`SLOT_COUNT];

    arcade_rom_top i_arcade_rom_top (
        .clk(clk), .rst_n(rst_n), .downloading(downloading), .ioctl(ioctl),
        .rom_req(rom_req), .sdram_rsp(sdram_rsp), .cen(cen), .prog(prog),
        .prom_we(prom_we), .rom_rsp(rom_rsp), .sdram_req(sdram_req)
    );

    always #50 clk = ~clk;

    // SDRAM model with random ack delay and random rdy gap for fetches
    always @(posedge clk) begin
        if (!rst_n) begin
            mphase    <= 0;
            sdram_rsp <= '0;
        end else begin
            case (mphase)
                0: if (downloading ? prog.we : sdram_req.req) begin
                    mcount  <= int'($urandom % 4) + 1;
                    m_fetch <= !downloading;
                    m_addr  <= sdram_req.addr;
                    if (!downloading)
                        fetch_log.push_back(sdram_req);
                    mphase  <= 1;
                end
                1: if (mcount == 1) begin
                    sdram_rsp.ack <= 1'b1;
                    mphase        <= 2;
                end else mcount <= mcount - 1;
                2: begin
                    sdram_rsp.ack <= 1'b0;
                    mcount        <= int'($urandom % 4) + 1;
                    mphase        <= m_fetch ? 3 : 0;
                end
                3: if (mcount == 1) begin
                    sdram_rsp.rdy  <= 1'b1;
                    sdram_rsp.data <= m_addr[15:0] ^ 16'h5a5a;
                    mphase         <= 4;
                end else mcount <= mcount - 1;
                default: begin
                    sdram_rsp.rdy <= 1'b0;
                    mphase        <= 0;
                end
            endcase
        end
    end

    initial begin
        #(watch_cycles * 100);
        $display("Timeout, the tests did not finish within %0d cycles", watch_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_cen(input arcade_pkg::cen_t got, input arcade_pkg::cen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t cen got %b exp %b", $time, got, exp);
        end
    endtask

    task automatic check_prog(input arcade_pkg::prog_t got, input arcade_pkg::prog_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t prog got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic check_prom(input logic [`PROM_COUNT-1:0] got,
                              input logic [`PROM_COUNT-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t prom_we got %b exp %b", $time, got, exp);
        end
    endtask

    task automatic check_rsp(input string name, input arcade_pkg::rom_rsp_t got,
                             input arcade_pkg::rom_rsp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_req(input arcade_pkg::sdram_req_t got,
                             input arcade_pkg::sdram_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t sdram_req got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic report(input string name, input int e0);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - e0);
    endtask

    task automatic send_byte(input logic [24:0] a, input logic [7:0] d);
        @(posedge clk) ioctl <= '{addr: a, dout: d, wr: 1'b1};
        @(posedge clk) ioctl.wr <= 1'b0;
    endtask

    // Checks the pending write until it is acknowledged
    task automatic hold_prog(input arcade_pkg::prog_t exp);
        int n;
        @(negedge clk) check_prog(prog, exp);
        n = 0;
        while (prog.we && n < 30) begin
            @(negedge clk);
            if (prog.we)
                check_prog(prog, exp);
            n++;
        end
        if (n >= 30) begin
            errors++;
            $display("Programming write was never acknowledged");
        end
    endtask

    // Waits until every slot with cs high reports ok
    task automatic wait_all_ok();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(rom_rsp[0].ok && rom_rsp[1].ok && rom_rsp[2].ok) && n < 100);
        if (n >= 100) begin
            errors++;
            $display("Slots did not all report ok in time");
        end
    endtask

    task automatic test_cen();
        int e0;
        arcade_pkg::cen_t exp;
        e0 = errors;
        for (int n = 0; n < 64; n++) begin
            @(negedge clk);
            exp.cen12 = n >= 1 && ((n - 1) % 4) == 3;
            exp.cen6  = n >= 1 && ((n - 1) % 8) == 7;
            exp.cen3  = n >= 1 && ((n - 1) % 16) == 15;
            check_cen(cen, exp);
        end
        report("cen", e0);
    endtask

    task automatic test_download();
        int e0;
        logic [24:0] a;
        arcade_pkg::prog_t exp;
        e0 = errors;
        @(posedge clk) downloading <= 1'b1;
        for (int k = 0; k < 2; k++) begin
            a   = 25'h01_2340 + 25'(k);  // Even then odd byte
            exp = '{addr: a[22:1], data: 8'h3c + 8'(k), mask: k ? 2'b01 : 2'b10, we: 1'b1};
            send_byte(a, exp.data);
            hold_prog(exp);
        end
        // Second byte lands while the first is pending
        a   = 25'h00_0816;
        exp = '{addr: a[22:1], data: 8'h77, mask: 2'b10, we: 1'b1};
        @(posedge clk) ioctl <= '{addr: a, dout: 8'h77, wr: 1'b1};
        @(posedge clk) ioctl <= '{addr: a + 25'd1, dout: 8'h88, wr: 1'b1};
        @(posedge clk) ioctl.wr <= 1'b0;
        hold_prog(exp);
        exp.we = 1'b0;
        repeat (8) @(negedge clk) check_prog(prog, exp);
        @(posedge clk) downloading <= 1'b0;
        report("download", e0);
    endtask

    task automatic test_prom();
        int e0;
        arcade_pkg::prog_t exp;
        e0 = errors;
        @(posedge clk) downloading <= 1'b1;
        for (int n = 0; n < `PROM_COUNT; n++) begin
            exp = '{addr: 22'(n), data: 8'ha0 + 8'(n), mask: 2'b11, we: 1'b0};
            send_byte(25'(`PROM_START + n * 256 + n), exp.data);
            @(negedge clk);
            check_prom(prom_we, `PROM_COUNT'(1) << n);
            check_prog(prog, exp);
            @(negedge clk);
            check_prom(prom_we, '0);
            check_prog(prog, exp);
        end
        @(posedge clk) downloading <= 1'b0;
        report("prom", e0);
    endtask

    task automatic test_fetch();
        int e0;
        int n;
        e0 = errors;
        for (int s = 0; s < `SLOT_COUNT; s++) begin
            cur_addr[s] = 17'($urandom);
            @(posedge clk) rom_req[s] <= '{cs: 1'b1, addr: cur_addr[s]};
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!rom_rsp[s].ok && n < 60);
            if (n >= 60) begin
                errors++;
                $display("Slot %0d fetch did not complete", s);
            end
            check_rsp($sformatf("rom_rsp[%0d]", s), rom_rsp[s],
                      '{ok: 1'b1, data: 16'(slot_off[s] + 22'(cur_addr[s])) ^ 16'h5a5a});
            @(posedge clk) rom_req[s].cs <= 1'b0;
        end
        report("fetch", e0);
    endtask

    task automatic check_all_slots();
        for (int s = 0; s < `SLOT_COUNT; s++)
            check_rsp($sformatf("rom_rsp[%0d]", s), rom_rsp[s],
                      '{ok: 1'b1, data: 16'(slot_off[s] + 22'(cur_addr[s])) ^ 16'h5a5a});
    endtask

    task automatic test_priority();
        int e0;
        e0 = errors;
        fetch_log.delete();
        @(posedge clk);
        for (int s = 0; s < `SLOT_COUNT; s++) begin
            cur_addr[s] = cur_addr[s] ^ 17'h155;
            rom_req[s] <= '{cs: 1'b1, addr: cur_addr[s]};
        end
        wait_all_ok();
        if (fetch_log.size() != 3) begin
            errors++;
            $display("Expected 3 SDRAM requests, saw %0d", fetch_log.size());
        end else begin
            for (int s = 0; s < `SLOT_COUNT; s++)
                check_req(fetch_log[s], '{req: 1'b1, addr: slot_off[s] + 22'(cur_addr[s])});
        end
        repeat (10) @(negedge clk) check_all_slots();
        if (fetch_log.size() != 3) begin
            errors++;
            $display("Cached slots issued extra SDRAM requests");
        end
        report("priority", e0);
    endtask

    task automatic test_flush();
        int e0;
        e0 = errors;
        @(posedge clk) downloading <= 1'b1;
        fetch_log.delete();
        @(posedge clk);
        repeat (8) begin
            @(negedge clk);
            for (int s = 0; s < `SLOT_COUNT; s++)
                check_rsp("rom_rsp.ok", '{ok: rom_rsp[s].ok, data: 16'd0}, '0);
            check_req('{req: sdram_req.req, addr: 22'd0}, '0);
        end
        @(posedge clk) downloading <= 1'b0;
        wait_all_ok();
        check_all_slots();
        if (fetch_log.size() != 3) begin
            errors++;
            $display("Expected 3 refetches after download, saw %0d", fetch_log.size());
        end
        report("flush", e0);
    endtask

    initial begin
        void'($urandom(32'ha6db));
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl       = '0;
        for (int s = 0; s < `SLOT_COUNT; s++)
            rom_req[s] = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_cen();
        test_download();
        test_prom();
        test_fetch();
        test_priority();
        test_flush();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/arcade_pkg.sv
design/cen_gen.sv
design/rom_dwnld.sv
design/rom_slots.sv
design/arcade_rom_top.sv
sim/arcade_rom_properties.sv
sim/arcade_rom_tb.sv

//--- Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = arcade_rom_tb
FLIST = flist.f
MDIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(MDIR) -o sim_bin
	./$(MDIR)/sim_bin | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(MDIR)
